/* ctcq_top.f */
+incdir+include
verilog/ctcq_pkg.sv
verilog/ctcq_entry.sv
verilog/ctcq_queue.sv
verilog/ctcq_launch.sv
verilog/ctcq_top.sv
test/ctcq_assertions.sv
test/ctcq_tb.sv

/* Makefile */
TOOL       = verilator
TOP        = ctcq_tb
FILELIST   = ctcq_top.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
PASS_MSG   = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the pipeline status is the status of grep, so a missing pass line fails the target
sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/ctcq_tb.sv */
// testbench for the maintenance queue, table driven against an in-order queue model
`timescale 1ns/1ps
`default_nettype none
`include "ctcq_cfg.svh"

module ctcq_tb
  import ctcq_pkg::*;
();

  localparam int ROW_CNT  = 10;
  localparam int WAIT_MAX = 20;

  typedef struct packed
  {
    ctc_op_e    op;
    logic [3:0] done_dly;
    logic [3:0] rdy_dly;
    logic       fdis;
  } row_t;

  // opcode, done delay, cr_ready delay, flush disable
  row_t rows [ROW_CNT] = '{
    '{OP_ICACHE_ALL_INV,   4'd0, 4'd0, 1'b0},
    '{OP_ICACHE_LINE_INV,  4'd2, 4'd1, 1'b0},
    '{OP_TLB_ALL_INV,      4'd1, 4'd3, 1'b1},
    '{OP_TLB_VA_ALL_INV,   4'd3, 4'd0, 1'b0},
    '{OP_TLB_ASID_ALL_INV, 4'd0, 4'd2, 1'b0},
    '{OP_TLB_VA_ASID_INV,  4'd4, 4'd1, 1'b1},
    '{OP_ICACHE_LINE_INV,  4'd1, 4'd0, 1'b0},
    '{OP_TLB_VA_ASID_INV,  4'd2, 4'd2, 1'b0},
    '{OP_ICACHE_ALL_INV,   4'd0, 4'd1, 1'b1},
    '{OP_TLB_ASID_ALL_INV, 4'd1, 4'd0, 1'b0}
  };

  logic                           ctcq_pe_clk;
  logic                           cpurst_b;
  logic                           create_en;
  ctc_op_e                        ctc_op;
  logic [`CTCQ_ASID_WIDTH-1:0]    ctc_asid;
  logic [`CTCQ_ADDR_WIDTH-1:0]    ctc_va_pa;
  logic [`CTCQ_ENTRIES-1:0]       oldest_index;
  logic                           cr_ready;
  logic                           icache_inv_done;
  logic                           tlb_inv_done;
  logic                           flush_dis;
  logic                           cur_entry_empty;
  logic                           cr_valid;
  logic                           not_empty;
  logic [`CTCQ_ENTRIES-1:0]       entry_vld;
  logic                           icache_all_inv;
  logic                           icache_line_inv;
  logic [`CTCQ_INDEX_WIDTH-1:0]   icache_index;
  logic [`CTCQ_PTAG_WIDTH-1:0]    icache_ptag;
  logic                           tlb_all_inv;
  logic                           tlb_va_all_inv;
  logic                           tlb_asid_all_inv;
  logic                           tlb_va_asid_inv;
  logic [`CTCQ_ASID_WIDTH-1:0]    tlb_asid;
  logic [`CTCQ_TLB_VA_WIDTH-1:0]  tlb_va;
  logic                           flush_vld;

  // reference model state
  logic [`CTCQ_ADDR_WIDTH-1:0]    row_addr [ROW_CNT];
  logic [`CTCQ_ASID_WIDTH-1:0]    row_asid [ROW_CNT];
  int                             launch_q [$];
  int                             resp_q [$];
  int                             resp_row_q [$];
  int                             create_slot;
  int                             val_errs;
  int                             other_errs;
  integer                         seed;
  logic [63:0]                    rnd;

  ctcq_top dut0 (.*);

  initial
  begin
    ctcq_pe_clk = 1'b0;
    forever #5 ctcq_pe_clk = ~ctcq_pe_clk;
  end

  // each row is applied about twice, well under 40 cycles per pass
  initial
  begin
    repeat (ROW_CNT * 40 + 200) @(posedge ctcq_pe_clk);
    $display("watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  //********************
  // helpers
  //********************
  task automatic report_err(input string name, input logic [63:0] exp, input logic [63:0] got);
    val_errs++;
    $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
  endtask

  function automatic logic [5:0] strobe_vec();
    return {icache_all_inv, icache_line_inv, tlb_all_inv,
            tlb_va_all_inv, tlb_asid_all_inv, tlb_va_asid_inv};
  endfunction

  // step to just after the next edge and drop the pulses
  task automatic next_cycle();
    @(posedge ctcq_pe_clk);
    #1;
    create_en       = 1'b0;
    icache_inv_done = 1'b0;
    tlb_inv_done    = 1'b0;
    cr_ready        = 1'b0;
  endtask

  task automatic update_oldest();
    oldest_index = '0;
    if (resp_q.size() > 0)
      oldest_index = `CTCQ_ENTRIES'(1) << resp_q[0];
  endtask

  // occupied slots as the model sees them
  function automatic logic [`CTCQ_ENTRIES-1:0] model_vld();
    logic [`CTCQ_ENTRIES-1:0] v;
    v = '0;
    foreach (resp_q[i])
      v |= `CTCQ_ENTRIES'(1) << resp_q[i];
    return v;
  endfunction

  task automatic create_req(input int r);
    next_cycle();
    if (cur_entry_empty !== 1'b1)
    begin
      $display("create of row %0d found the current entry occupied", r);
      other_errs++;
    end
    create_en = 1'b1;
    ctc_op    = rows[r].op;
    ctc_asid  = row_asid[r];
    ctc_va_pa = row_addr[r];
    launch_q.push_back(r);
    resp_q.push_back(create_slot);
    resp_row_q.push_back(r);
    create_slot = (create_slot + 1) % `CTCQ_ENTRIES;
    update_oldest();
  endtask

  task automatic serve_next();
    int         r;
    int         n;
    logic [5:0] exp_strb;
    r        = launch_q.pop_front();
    exp_strb = 6'b100000 >> rows[r].op;
    n        = 0;
    next_cycle();
    while (strobe_vec() == 6'b0 && n < WAIT_MAX)
    begin
      next_cycle();
      n++;
    end
    if (n == WAIT_MAX)
    begin
      $display("no invalidate strobe seen for row %0d", r);
      other_errs++;
      return;
    end
    if (strobe_vec() !== exp_strb)
      report_err("strobes", 64'(exp_strb), 64'(strobe_vec()));
    // field slices of pa[39:4]
    if (icache_ptag !== row_addr[r][35:8])
      report_err("icache_ptag", 64'(row_addr[r][35:8]), 64'(icache_ptag));
    if (icache_index !== row_addr[r][7:2])
      report_err("icache_index", 64'(row_addr[r][7:2]), 64'(icache_index));
    if (tlb_va !== row_addr[r][34:8])
      report_err("tlb_va", 64'(row_addr[r][34:8]), 64'(tlb_va));
    if (tlb_asid !== row_asid[r])
      report_err("tlb_asid", 64'(row_asid[r]), 64'(tlb_asid));
    repeat (rows[r].done_dly)
    begin
      next_cycle();
      if (strobe_vec() !== exp_strb)
        report_err("strobes held", 64'(exp_strb), 64'(strobe_vec()));
    end
    if (rows[r].op == OP_ICACHE_ALL_INV || rows[r].op == OP_ICACHE_LINE_INV)
      icache_inv_done = 1'b1;
    else
      tlb_inv_done = 1'b1;
    flush_dis = rows[r].fdis;
    next_cycle();
    if (strobe_vec() !== 6'b0)
      report_err("strobes after done", 64'(0), 64'(strobe_vec()));
    if (flush_vld !== !rows[r].fdis)
      report_err("flush_vld", 64'(!rows[r].fdis), 64'(flush_vld));
  endtask

  task automatic respond_oldest();
    int r;
    r = resp_row_q[0];
    next_cycle();
    if (cr_valid !== 1'b1)
      report_err("cr_valid", 64'(1), 64'(cr_valid));
    // back-pressure from the bus
    repeat (rows[r].rdy_dly)
    begin
      next_cycle();
      if (cr_valid !== 1'b1)
        report_err("cr_valid held", 64'(1), 64'(cr_valid));
    end
    cr_ready = 1'b1;
    next_cycle();
    void'(resp_q.pop_front());
    void'(resp_row_q.pop_front());
    if (entry_vld !== model_vld())
      report_err("entry_vld", 64'(model_vld()), 64'(entry_vld));
    update_oldest();
  endtask

  //********************
  // main sequence
  //********************
  initial
  begin
    seed            = 32'hb50a;
    val_errs        = 0;
    other_errs      = 0;
    create_slot     = 0;
    cpurst_b        = 1'b0;
    create_en       = 1'b0;
    ctc_op          = OP_ICACHE_ALL_INV;
    ctc_asid        = '0;
    ctc_va_pa       = '0;
    oldest_index    = '0;
    cr_ready        = 1'b0;
    icache_inv_done = 1'b0;
    tlb_inv_done    = 1'b0;
    flush_dis       = 1'b0;
    for (int i = 0; i < ROW_CNT; i++)
    begin
      rnd         = {$random(seed), $random(seed)};
      row_addr[i] = rnd[35:0];
      row_asid[i] = rnd[51:36];
    end

    repeat (2) @(posedge ctcq_pe_clk);
    #1;
    cpurst_b = 1'b1;
    if (strobe_vec() !== 6'b0)
      report_err("strobes", 64'(0), 64'(strobe_vec()));
    if (cr_valid !== 1'b0)
      report_err("cr_valid", 64'(0), 64'(cr_valid));
    if (flush_vld !== 1'b0)
      report_err("flush_vld", 64'(0), 64'(flush_vld));
    if (not_empty !== 1'b0)
      report_err("not_empty", 64'(0), 64'(not_empty));
    if (cur_entry_empty !== 1'b1)
      report_err("cur_entry_empty", 64'(1), 64'(cur_entry_empty));

    // one request at a time through every row
    for (int r = 0; r < ROW_CNT; r++)
    begin
      create_req(r);
      serve_next();
      respond_oldest();
    end

    // back to back creates, launched in order
    for (int r = 0; r < 3; r++)
      create_req(r);
    repeat (3) serve_next();
    repeat (3) respond_oldest();

    // fill all six entries
    for (int r = 3; r < 9; r++)
      create_req(r);
    next_cycle();
    if (cur_entry_empty !== 1'b0)
      report_err("cur_entry_empty full", 64'(0), 64'(cur_entry_empty));
    if (not_empty !== 1'b1)
      report_err("not_empty full", 64'(1), 64'(not_empty));
    serve_next();
    respond_oldest();
    create_req(9);
    repeat (6) serve_next();
    repeat (6) respond_oldest();

    next_cycle();
    if (not_empty !== 1'b0)
      report_err("not_empty drained", 64'(0), 64'(not_empty));

    $display("tests done: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/ctcq_assertions.sv */
// protocol assertions bound onto the maintenance queue top level
`timescale 1ns/1ps
`default_nettype none

module ctcq_assertions
(
  input wire ctcq_pe_clk,
  input wire cpurst_b,
  input wire create_en,
  input wire cur_entry_empty,
  input wire icache_all_inv,
  input wire icache_line_inv,
  input wire tlb_all_inv,
  input wire tlb_va_all_inv,
  input wire tlb_asid_all_inv,
  input wire tlb_va_asid_inv,
  input wire flush_vld
);

  // arbiter only creates into a free entry
  create_into_free: assert property (@(posedge ctcq_pe_clk) disable iff (!cpurst_b)
    create_en |-> cur_entry_empty)
    else $error("create_en asserted while the entry at the create pointer is occupied");

  // one request in flight at a time
  single_strobe: assert property (@(posedge ctcq_pe_clk) disable iff (!cpurst_b)
    $onehot0({icache_all_inv, icache_line_inv, tlb_all_inv,
              tlb_va_all_inv, tlb_asid_all_inv, tlb_va_asid_inv}))
    else $error("more than one invalidate strobe high");

  // flush is a single-cycle pulse
  flush_one_cycle: assert property (@(posedge ctcq_pe_clk) disable iff (!cpurst_b)
    flush_vld |=> !flush_vld)
    else $error("flush_vld high for two cycles in a row");

endmodule

bind ctcq_top ctcq_assertions u_assertions (
  .ctcq_pe_clk      (ctcq_pe_clk),
  .cpurst_b         (cpurst_b),
  .create_en        (create_en),
  .cur_entry_empty  (cur_entry_empty),
  .icache_all_inv   (icache_all_inv),
  .icache_line_inv  (icache_line_inv),
  .tlb_all_inv      (tlb_all_inv),
  .tlb_va_all_inv   (tlb_va_all_inv),
  .tlb_asid_all_inv (tlb_asid_all_inv),
  .tlb_va_asid_inv  (tlb_va_asid_inv),
  .flush_vld        (flush_vld)
);

`default_nettype wire

/* verilog/ctcq_top.sv */
// cache and tlb maintenance request queue for the lsu snoop path
`timescale 1ns/1ps
`default_nettype none
`include "ctcq_cfg.svh"

module ctcq_top
  import ctcq_pkg::*;
(
  input  wire                            ctcq_pe_clk,
  input  wire                            cpurst_b,
  input  logic                           create_en,
  input  ctc_op_e                        ctc_op,
  input  logic [`CTCQ_ASID_WIDTH-1:0]    ctc_asid,
  input  logic [`CTCQ_ADDR_WIDTH-1:0]    ctc_va_pa,
  input  logic [`CTCQ_ENTRIES-1:0]       oldest_index,
  input  logic                           cr_ready,
  input  logic                           icache_inv_done,
  input  logic                           tlb_inv_done,
  input  logic                           flush_dis,
  output logic                           cur_entry_empty,
  output logic                           cr_valid,
  output logic                           not_empty,
  output logic [`CTCQ_ENTRIES-1:0]       entry_vld,
  output logic                           icache_all_inv,
  output logic                           icache_line_inv,
  output logic [`CTCQ_INDEX_WIDTH-1:0]   icache_index,
  output logic [`CTCQ_PTAG_WIDTH-1:0]    icache_ptag,
  output logic                           tlb_all_inv,
  output logic                           tlb_va_all_inv,
  output logic                           tlb_asid_all_inv,
  output logic                           tlb_va_asid_inv,
  output logic [`CTCQ_ASID_WIDTH-1:0]    tlb_asid,
  output logic [`CTCQ_TLB_VA_WIDTH-1:0]  tlb_va,
  output logic                           flush_vld
);

  logic [`CTCQ_ENTRIES-1:0]                          pending;
  logic [`CTCQ_ENTRIES-1:0]                          launch_cmplt;
  logic [`CTCQ_ENTRIES-1:0]                          ent_icache_all_inv;
  logic [`CTCQ_ENTRIES-1:0]                          ent_icache_line_inv;
  logic [`CTCQ_ENTRIES-1:0][`CTCQ_INDEX_WIDTH-1:0]   ent_icache_index;
  logic [`CTCQ_ENTRIES-1:0][`CTCQ_PTAG_WIDTH-1:0]    ent_icache_ptag;
  logic [`CTCQ_ENTRIES-1:0]                          ent_tlb_all_inv;
  logic [`CTCQ_ENTRIES-1:0]                          ent_tlb_va_all_inv;
  logic [`CTCQ_ENTRIES-1:0]                          ent_tlb_asid_all_inv;
  logic [`CTCQ_ENTRIES-1:0]                          ent_tlb_va_asid_inv;
  logic [`CTCQ_ENTRIES-1:0][`CTCQ_ASID_WIDTH-1:0]    ent_tlb_asid;
  logic [`CTCQ_ENTRIES-1:0][`CTCQ_TLB_VA_WIDTH-1:0]  ent_tlb_va;

  ctcq_queue u_queue (
    .ctcq_pe_clk          (ctcq_pe_clk),
    .cpurst_b             (cpurst_b),
    .create_en            (create_en),
    .ctc_op               (ctc_op),
    .ctc_asid             (ctc_asid),
    .ctc_va_pa            (ctc_va_pa),
    .launch_cmplt         (launch_cmplt),
    .oldest_index         (oldest_index),
    .cr_ready             (cr_ready),
    .pending              (pending),
    .ent_icache_all_inv   (ent_icache_all_inv),
    .ent_icache_line_inv  (ent_icache_line_inv),
    .ent_icache_index     (ent_icache_index),
    .ent_icache_ptag      (ent_icache_ptag),
    .ent_tlb_all_inv      (ent_tlb_all_inv),
    .ent_tlb_va_all_inv   (ent_tlb_va_all_inv),
    .ent_tlb_asid_all_inv (ent_tlb_asid_all_inv),
    .ent_tlb_va_asid_inv  (ent_tlb_va_asid_inv),
    .ent_tlb_asid         (ent_tlb_asid),
    .ent_tlb_va           (ent_tlb_va),
    .cur_entry_empty      (cur_entry_empty),
    .cr_valid             (cr_valid),
    .not_empty            (not_empty),
    .entry_vld            (entry_vld)
  );

  ctcq_launch u_launch (
    .ctcq_pe_clk          (ctcq_pe_clk),
    .cpurst_b             (cpurst_b),
    .pending              (pending),
    .ent_icache_all_inv   (ent_icache_all_inv),
    .ent_icache_line_inv  (ent_icache_line_inv),
    .ent_icache_index     (ent_icache_index),
    .ent_icache_ptag      (ent_icache_ptag),
    .ent_tlb_all_inv      (ent_tlb_all_inv),
    .ent_tlb_va_all_inv   (ent_tlb_va_all_inv),
    .ent_tlb_asid_all_inv (ent_tlb_asid_all_inv),
    .ent_tlb_va_asid_inv  (ent_tlb_va_asid_inv),
    .ent_tlb_asid         (ent_tlb_asid),
    .ent_tlb_va           (ent_tlb_va),
    .icache_inv_done      (icache_inv_done),
    .tlb_inv_done         (tlb_inv_done),
    .flush_dis            (flush_dis),
    .launch_cmplt         (launch_cmplt),
    .icache_all_inv       (icache_all_inv),
    .icache_line_inv      (icache_line_inv),
    .icache_index         (icache_index),
    .icache_ptag          (icache_ptag),
    .tlb_all_inv          (tlb_all_inv),
    .tlb_va_all_inv       (tlb_va_all_inv),
    .tlb_asid_all_inv     (tlb_asid_all_inv),
    .tlb_va_asid_inv      (tlb_va_asid_inv),
    .tlb_asid             (tlb_asid),
    .tlb_va               (tlb_va),
    .flush_vld            (flush_vld)
  );

endmodule

`default_nettype wire

/* verilog/ctcq_launch.sv */
// launch stage sending one queued request at a time to icache or tlb
`timescale 1ns/1ps
`default_nettype none
`include "ctcq_cfg.svh"

module ctcq_launch
  import ctcq_pkg::*;
(
  input  wire                                              ctcq_pe_clk,
  input  wire                                              cpurst_b,
  input  logic [`CTCQ_ENTRIES-1:0]                         pending,
  input  logic [`CTCQ_ENTRIES-1:0]                         ent_icache_all_inv,
  input  logic [`CTCQ_ENTRIES-1:0]                         ent_icache_line_inv,
  input  logic [`CTCQ_ENTRIES-1:0][`CTCQ_INDEX_WIDTH-1:0]  ent_icache_index,
  input  logic [`CTCQ_ENTRIES-1:0][`CTCQ_PTAG_WIDTH-1:0]   ent_icache_ptag,
  input  logic [`CTCQ_ENTRIES-1:0]                         ent_tlb_all_inv,
  input  logic [`CTCQ_ENTRIES-1:0]                         ent_tlb_va_all_inv,
  input  logic [`CTCQ_ENTRIES-1:0]                         ent_tlb_asid_all_inv,
  input  logic [`CTCQ_ENTRIES-1:0]                         ent_tlb_va_asid_inv,
  input  logic [`CTCQ_ENTRIES-1:0][`CTCQ_ASID_WIDTH-1:0]   ent_tlb_asid,
  input  logic [`CTCQ_ENTRIES-1:0][`CTCQ_TLB_VA_WIDTH-1:0] ent_tlb_va,
  input  logic                                             icache_inv_done,
  input  logic                                             tlb_inv_done,
  input  logic                                             flush_dis,
  output logic [`CTCQ_ENTRIES-1:0]                         launch_cmplt,
  output logic                                             icache_all_inv,
  output logic                                             icache_line_inv,
  output logic [`CTCQ_INDEX_WIDTH-1:0]                     icache_index,
  output logic [`CTCQ_PTAG_WIDTH-1:0]                      icache_ptag,
  output logic                                             tlb_all_inv,
  output logic                                             tlb_va_all_inv,
  output logic                                             tlb_asid_all_inv,
  output logic                                             tlb_va_asid_inv,
  output logic [`CTCQ_ASID_WIDTH-1:0]                      tlb_asid,
  output logic [`CTCQ_TLB_VA_WIDTH-1:0]                    tlb_va,
  output logic                                             flush_vld
);

  pe_state_e                      pe_state;
  logic [`CTCQ_ENTRIES-1:0]       launch_ptr;
  logic                           sel_pending;
  logic                           inv_done;
  logic                           req_go;
  logic                           busy;
  logic [`CTCQ_INDEX_WIDTH-1:0]   sel_icache_index;
  logic [`CTCQ_PTAG_WIDTH-1:0]    sel_icache_ptag;
  logic [`CTCQ_ASID_WIDTH-1:0]    sel_tlb_asid;
  logic [`CTCQ_TLB_VA_WIDTH-1:0]  sel_tlb_va;
  logic [5:0]                     req_flags;

  //********************
  // entry select
  //********************
  assign sel_pending = |(pending & launch_ptr);

  // and-or mux over the one-hot launch pointer
  always_comb
  begin
    sel_icache_index = '0;
    sel_icache_ptag  = '0;
    sel_tlb_asid     = '0;
    sel_tlb_va       = '0;
    for (int i = 0; i < `CTCQ_ENTRIES; i++)
    begin
      sel_icache_index |= ent_icache_index[i] & {`CTCQ_INDEX_WIDTH{launch_ptr[i]}};
      sel_icache_ptag  |= ent_icache_ptag[i]  & {`CTCQ_PTAG_WIDTH{launch_ptr[i]}};
      sel_tlb_asid     |= ent_tlb_asid[i]     & {`CTCQ_ASID_WIDTH{launch_ptr[i]}};
      sel_tlb_va       |= ent_tlb_va[i]       & {`CTCQ_TLB_VA_WIDTH{launch_ptr[i]}};
    end
  end

  //********************
  // launch control
  //********************
  assign busy     = (pe_state == PE_WAIT_DONE);
  assign req_go   = (pe_state == PE_IDLE) & sel_pending;
  // done pulses outside a request are ignored
  assign inv_done = busy & (icache_inv_done | tlb_inv_done);

  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pe_state <= PE_IDLE;
    else
    begin
      case (pe_state)
        PE_IDLE:      if (sel_pending) pe_state <= PE_WAIT_DONE;
        PE_WAIT_DONE: if (inv_done) pe_state <= PE_IDLE;
        default:      pe_state <= PE_IDLE;
      endcase
    end
  end

  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      launch_ptr <= {{(`CTCQ_ENTRIES-1){1'b0}}, 1'b1};
    else if (inv_done)
      launch_ptr <= {launch_ptr[`CTCQ_ENTRIES-2:0], launch_ptr[`CTCQ_ENTRIES-1]};
  end

  assign launch_cmplt = {`CTCQ_ENTRIES{inv_done}} & launch_ptr;

  // async flush, one cycle after done
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      flush_vld <= 1'b0;
    else
      flush_vld <= inv_done & ~flush_dis;
  end

  //********************
  // held request
  //********************
  always_ff @(posedge ctcq_pe_clk)
  begin
    if (req_go)
    begin
      req_flags    <= {|(ent_icache_all_inv & launch_ptr),
                       |(ent_icache_line_inv & launch_ptr),
                       |(ent_tlb_all_inv & launch_ptr),
                       |(ent_tlb_va_all_inv & launch_ptr),
                       |(ent_tlb_asid_all_inv & launch_ptr),
                       |(ent_tlb_va_asid_inv & launch_ptr)};
      icache_index <= sel_icache_index;
      icache_ptag  <= sel_icache_ptag;
      tlb_asid     <= sel_tlb_asid;
      tlb_va       <= sel_tlb_va;
    end
  end

  // strobes are levels held until done
  assign icache_all_inv   = busy & req_flags[5];
  assign icache_line_inv  = busy & req_flags[4];
  assign tlb_all_inv      = busy & req_flags[3];
  assign tlb_va_all_inv   = busy & req_flags[2];
  assign tlb_asid_all_inv = busy & req_flags[1];
  assign tlb_va_asid_inv  = busy & req_flags[0];

endmodule

`default_nettype wire

/* verilog/ctcq_queue.sv */
// entry array with in-order create pointer and oldest-entry response return
`timescale 1ns/1ps
`default_nettype none
`include "ctcq_cfg.svh"

module ctcq_queue
  import ctcq_pkg::*;
(
  input  wire                                                ctcq_pe_clk,
  input  wire                                                cpurst_b,
  input  logic                                               create_en,
  input  ctc_op_e                                            ctc_op,
  input  logic [`CTCQ_ASID_WIDTH-1:0]                        ctc_asid,
  input  logic [`CTCQ_ADDR_WIDTH-1:0]                        ctc_va_pa,
  input  logic [`CTCQ_ENTRIES-1:0]                           launch_cmplt,
  input  logic [`CTCQ_ENTRIES-1:0]                           oldest_index,
  input  logic                                               cr_ready,
  output logic [`CTCQ_ENTRIES-1:0]                           pending,
  output logic [`CTCQ_ENTRIES-1:0]                           ent_icache_all_inv,
  output logic [`CTCQ_ENTRIES-1:0]                           ent_icache_line_inv,
  output logic [`CTCQ_ENTRIES-1:0][`CTCQ_INDEX_WIDTH-1:0]    ent_icache_index,
  output logic [`CTCQ_ENTRIES-1:0][`CTCQ_PTAG_WIDTH-1:0]     ent_icache_ptag,
  output logic [`CTCQ_ENTRIES-1:0]                           ent_tlb_all_inv,
  output logic [`CTCQ_ENTRIES-1:0]                           ent_tlb_va_all_inv,
  output logic [`CTCQ_ENTRIES-1:0]                           ent_tlb_asid_all_inv,
  output logic [`CTCQ_ENTRIES-1:0]                           ent_tlb_va_asid_inv,
  output logic [`CTCQ_ENTRIES-1:0][`CTCQ_ASID_WIDTH-1:0]     ent_tlb_asid,
  output logic [`CTCQ_ENTRIES-1:0][`CTCQ_TLB_VA_WIDTH-1:0]   ent_tlb_va,
  output logic                                               cur_entry_empty,
  output logic                                               cr_valid,
  output logic                                               not_empty,
  output logic [`CTCQ_ENTRIES-1:0]                           entry_vld
);

  logic [`CTCQ_ENTRIES-1:0] create_ptr;
  logic [`CTCQ_ENTRIES-1:0] entry_create;
  logic [`CTCQ_ENTRIES-1:0] entry_cmplt;
  logic [`CTCQ_ENTRIES-1:0] resp_index;
  logic [`CTCQ_ENTRIES-1:0] resp_accept;

  //********************
  // create pointer
  //********************
  // one-hot, rotates by one per created request
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      create_ptr <= {{(`CTCQ_ENTRIES-1){1'b0}}, 1'b1};
    else if (create_en)
      create_ptr <= {create_ptr[`CTCQ_ENTRIES-2:0], create_ptr[`CTCQ_ENTRIES-1]};
  end

  assign entry_create    = {`CTCQ_ENTRIES{create_en}} & create_ptr;
  assign cur_entry_empty = |(create_ptr & ~entry_vld);
  assign not_empty       = |entry_vld;

  //********************
  // response return
  //********************
  assign resp_index  = entry_cmplt & oldest_index;
  assign cr_valid    = |resp_index;
  assign resp_accept = {`CTCQ_ENTRIES{cr_ready}} & resp_index;

  for (genvar i = 0; i < `CTCQ_ENTRIES; i++)
  begin : g_entry
    ctcq_entry u_entry (
      .ctcq_pe_clk      (ctcq_pe_clk),
      .cpurst_b         (cpurst_b),
      .create_en        (entry_create[i]),
      .ctc_op           (ctc_op),
      .ctc_asid         (ctc_asid),
      .ctc_va_pa        (ctc_va_pa),
      .launch_cmplt     (launch_cmplt[i]),
      .resp_accept      (resp_accept[i]),
      .vld              (entry_vld[i]),
      .cmplt            (entry_cmplt[i]),
      .pending          (pending[i]),
      .icache_all_inv   (ent_icache_all_inv[i]),
      .icache_line_inv  (ent_icache_line_inv[i]),
      .icache_index     (ent_icache_index[i]),
      .icache_ptag      (ent_icache_ptag[i]),
      .tlb_all_inv      (ent_tlb_all_inv[i]),
      .tlb_va_all_inv   (ent_tlb_va_all_inv[i]),
      .tlb_asid_all_inv (ent_tlb_asid_all_inv[i]),
      .tlb_va_asid_inv  (ent_tlb_va_asid_inv[i]),
      .tlb_asid         (ent_tlb_asid[i]),
      .tlb_va           (ent_tlb_va[i])
    );
  end

endmodule

`default_nettype wire

/* verilog/ctcq_entry.sv */
// single queue entry holding one maintenance request and its decoded fields
`timescale 1ns/1ps
`default_nettype none
`include "ctcq_cfg.svh"

module ctcq_entry
  import ctcq_pkg::*;
(
  input  wire                           ctcq_pe_clk,
  input  wire                           cpurst_b,
  input  logic                          create_en,
  input  ctc_op_e                       ctc_op,
  input  logic [`CTCQ_ASID_WIDTH-1:0]   ctc_asid,
  input  logic [`CTCQ_ADDR_WIDTH-1:0]   ctc_va_pa,
  input  logic                          launch_cmplt,
  input  logic                          resp_accept,
  output logic                          vld,
  output logic                          cmplt,
  output logic                          pending,
  output logic                          icache_all_inv,
  output logic                          icache_line_inv,
  output logic [`CTCQ_INDEX_WIDTH-1:0]  icache_index,
  output logic [`CTCQ_PTAG_WIDTH-1:0]   icache_ptag,
  output logic                          tlb_all_inv,
  output logic                          tlb_va_all_inv,
  output logic                          tlb_asid_all_inv,
  output logic                          tlb_va_asid_inv,
  output logic [`CTCQ_ASID_WIDTH-1:0]   tlb_asid,
  output logic [`CTCQ_TLB_VA_WIDTH-1:0] tlb_va
);

  ctc_op_e                     op;
  logic [`CTCQ_ASID_WIDTH-1:0] asid;
  logic [`CTCQ_ADDR_WIDTH-1:0] addr;

  // valid and complete tracking
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      vld   <= 1'b0;
      cmplt <= 1'b0;
    end
    else if (create_en)
    begin
      vld   <= 1'b1;
      cmplt <= 1'b0;
    end
    else if (resp_accept)
    begin
      vld   <= 1'b0;
      cmplt <= 1'b0;
    end
    else if (launch_cmplt)
      cmplt <= 1'b1;
  end

  // request content
  always_ff @(posedge ctcq_pe_clk)
  begin
    if (create_en)
    begin
      op   <= ctc_op;
      asid <= ctc_asid;
      addr <= ctc_va_pa;
    end
  end

  assign pending = vld & ~cmplt;

  //********************
  // opcode decode
  //********************
  assign icache_all_inv   = (op == OP_ICACHE_ALL_INV);
  assign icache_line_inv  = (op == OP_ICACHE_LINE_INV);
  assign tlb_all_inv      = (op == OP_TLB_ALL_INV);
  assign tlb_va_all_inv   = (op == OP_TLB_VA_ALL_INV);
  assign tlb_asid_all_inv = (op == OP_TLB_ASID_ALL_INV);
  assign tlb_va_asid_inv  = (op == OP_TLB_VA_ASID_INV);

  // stored address holds pa[39:4], so the slices are shifted by 4
  assign icache_ptag  = addr[`CTCQ_ADDR_WIDTH-1 -: `CTCQ_PTAG_WIDTH];
  assign icache_index = addr[`CTCQ_INDEX_WIDTH+1:2];
  assign tlb_va       = addr[`CTCQ_TLB_VA_WIDTH+7:8];
  assign tlb_asid     = asid;

endmodule

`default_nettype wire

/* verilog/ctcq_pkg.sv */
// shared opcode and launch state types for the maintenance queue
`default_nettype none

package ctcq_pkg;

  // maintenance request opcodes
  typedef enum logic [2:0]
  {
    OP_ICACHE_ALL_INV   = 3'd0,
    OP_ICACHE_LINE_INV  = 3'd1,
    OP_TLB_ALL_INV      = 3'd2,
    OP_TLB_VA_ALL_INV   = 3'd3,
    OP_TLB_ASID_ALL_INV = 3'd4,
    OP_TLB_VA_ASID_INV  = 3'd5
  } ctc_op_e;

  // launch stage states
  typedef enum logic
  {
    PE_IDLE      = 1'b0,
    PE_WAIT_DONE = 1'b1
  } pe_state_e;

endpackage

`default_nettype wire

/* include/ctcq_cfg.svh */
// cache/tlb maintenance queue sizing and address field widths
`ifndef CTCQ_CFG_SVH
`define CTCQ_CFG_SVH

// queue depth
`define CTCQ_ENTRIES      6

// address widths
`define CTCQ_PA_WIDTH     40
`define CTCQ_VA_WIDTH     39
`define CTCQ_ASID_WIDTH   16

// stored address keeps pa bits 39 down to 4
`define CTCQ_ADDR_WIDTH   (`CTCQ_PA_WIDTH - 4)

// decoded invalidate fields
`define CTCQ_PTAG_WIDTH   (`CTCQ_PA_WIDTH - 12)
`define CTCQ_INDEX_WIDTH  6
`define CTCQ_TLB_VA_WIDTH (`CTCQ_VA_WIDTH - 12)

`endif
